// File: all.f
+incdir+.
mem_pkg.sv
lsu_align.sv
dmem_ctrl.sv
mem_stage.sv
mem_top.sv
mem_sva.sv
tb_mem_top.sv

// File: tb_mem_top.sv
// ----------------------------------------------------------------------
// memory stage testbench
// table of records streamed back to back, checked against a RAM mirror
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "mem_settings.svh"

module tb_mem_top;
    import mem_pkg::*;

    localparam int MAX_ENT = 128;
    localparam int TIMEOUT = 50;

    logic     clk = 1'b0;
    logic     rst;
    ex_mem_t  ex_in;
    logic     ex_valid;
    logic     ex_ready;
    wb_fwd_t  wb_fwd;
    mem_wb_t  wb_out;
    logic     wb_valid;
    logic     wb_ready;

    string    t_name [MAX_ENT];
    ex_mem_t  t_ex [MAX_ENT];
    wb_fwd_t  t_fwd [MAX_ENT];
    int       t_stall [MAX_ENT];    // cycles wb_ready stays low
    logic     e_wen [MAX_ENT];
    reg_idx_t e_rd [MAX_ENT];
    xdata_t   e_wdata [MAX_ENT];
    int       n_ent = 0;
    xdata_t   mirror [`DMEM_WORDS];
    int       seed = 32'hcef893a2;

    always #5 clk = ~clk;

    mem_top i_mem_top (
        .clk      (clk),
        .rst      (rst),
        .ex_in    (ex_in),
        .ex_valid (ex_valid),
        .ex_ready (ex_ready),
        .wb_fwd   (wb_fwd),
        .wb_out   (wb_out),
        .wb_valid (wb_valid),
        .wb_ready (wb_ready)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    function automatic int access_bytes(input mem_op_t op);
        case (op)
            op_lb, op_lbu, op_sb: return 1;
            op_lh, op_lhu, op_sh: return 2;
            op_lw, op_lwu, op_sw: return 4;
            op_ld, op_sd:         return 8;
            default:              return 0;
        endcase
    endfunction

    function automatic logic touches_ram(input mem_op_t op);
        return access_bytes(op) != 0;
    endfunction

    // appends one record and predicts its writeback from the mirror
    task automatic add_op(input string name, input mem_op_t op, input reg_idx_t rd,
                          input reg_idx_t rs2, input xaddr_t addr, input xdata_t src2,
                          input wb_fwd_t fwd, input int stall);
        int     lane;
        int     idx;
        xdata_t data;
        xdata_t raw;
        lane = addr[2:0];
        idx  = addr[10:3];
        t_name[n_ent]       = name;
        t_ex[n_ent].pc      = 64'h1000 + n_ent * 4;
        t_ex[n_ent].rd      = rd;
        t_ex[n_ent].rs2     = rs2;
        t_ex[n_ent].op      = op;
        t_ex[n_ent].alu_out = addr;
        t_ex[n_ent].src2    = src2;
        t_fwd[n_ent]        = fwd;
        t_stall[n_ent]      = stall;
        e_rd[n_ent]         = rd;
        e_wen[n_ent]        = 1'b0;
        e_wdata[n_ent]      = addr;
        raw = mirror[idx] >> (lane * 8);
        case (op)
            op_alu: e_wen[n_ent] = 1'b1;
            op_lb:  e_wdata[n_ent] = 64'($signed(raw[7:0]));
            op_lh:  e_wdata[n_ent] = 64'($signed(raw[15:0]));
            op_lw:  e_wdata[n_ent] = 64'($signed(raw[31:0]));
            op_ld:  e_wdata[n_ent] = raw;
            op_lbu: e_wdata[n_ent] = 64'(raw[7:0]);
            op_lhu: e_wdata[n_ent] = 64'(raw[15:0]);
            op_lwu: e_wdata[n_ent] = 64'(raw[31:0]);
            default: ;
        endcase
        if (op inside {op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu}) begin
            e_wen[n_ent] = 1'b1;
        end
        if (op inside {op_sb, op_sh, op_sw, op_sd}) begin
            data = (fwd.wen && fwd.rd != 0 && fwd.rd == rs2) ? fwd.wdata : src2;
            for (int i = 0; i < access_bytes(op); i++) begin
                mirror[idx][(lane + i) * 8 +: 8] = data[i * 8 +: 8];
            end
        end
        n_ent++;
    endtask

    task automatic store_and_read(input string name, input mem_op_t op, input xaddr_t addr,
                                  input xdata_t data);
        add_op(name, op, 5'd0, 5'd3, addr, data, '0, 0);
        add_op({name, "_rd"}, op_ld, 5'd9, 5'd0, {addr[63:3], 3'b000}, '0, '0, 0);
    endtask

    task automatic build_table();
        add_op("alu_basic", op_alu, 5'd5, 5'd0, 64'h1234_5678_9abc_def0, '0, '0, 0);
        for (int w = 0; w < 4; w++) begin
            store_and_read("init_sd", op_sd, 64'(w * 8), {$random(seed), $random(seed)});
        end
        store_and_read("sw_hi", op_sw, 64'h04, 64'hdead_beef_a5a5_5a5a);
        store_and_read("sh_lane2", op_sh, 64'h0a, 64'h1111_2222_3333_c0de);
        store_and_read("sb_lane3", op_sb, 64'h13, 64'hffff_ffff_ffff_ff7e);
        store_and_read("sb_lane7", op_sb, 64'h1f, 64'h0000_0000_0000_0081);
        add_op("ld_word", op_sd, 5'd0, 5'd4, 64'h20, 64'h7f80_41c2_e305_96a7, '0, 0);
        add_op("ld_word", op_sd, 5'd0, 5'd4, 64'h28, 64'h807f_be3d_1cfa_6958, '0, 0);
        for (int w = 0; w < 2; w++) begin
            for (int b = 0; b < 8; b++) begin
                add_op("lb", op_lb, 5'd6, 5'd0, 64'h20 + w * 8 + b, '0, '0, 0);
                add_op("lbu", op_lbu, 5'd7, 5'd0, 64'h20 + w * 8 + b, '0, '0, 0);
            end
            for (int b = 0; b < 8; b += 2) begin
                add_op("lh", op_lh, 5'd6, 5'd0, 64'h20 + w * 8 + b, '0, '0, 0);
                add_op("lhu", op_lhu, 5'd7, 5'd0, 64'h20 + w * 8 + b, '0, '0, 0);
            end
            for (int b = 0; b < 8; b += 4) begin
                add_op("lw", op_lw, 5'd6, 5'd0, 64'h20 + w * 8 + b, '0, '0, 0);
                add_op("lwu", op_lwu, 5'd7, 5'd0, 64'h20 + w * 8 + b, '0, '0, 0);
            end
        end
        // forwarding hit, then rd zero, then write enable off
        add_op("fwd_hit", op_sd, 5'd0, 5'd7, 64'h30, 64'h1,
               {1'b1, 5'd7, 64'hfeed_f00d_0bad_cafe}, 0);
        add_op("fwd_hit_rd", op_ld, 5'd8, 5'd0, 64'h30, '0, '0, 0);
        add_op("fwd_x0", op_sd, 5'd0, 5'd0, 64'h38, 64'h2222, {1'b1, 5'd0, 64'h9999}, 0);
        add_op("fwd_x0_rd", op_ld, 5'd8, 5'd0, 64'h38, '0, '0, 0);
        add_op("fwd_off", op_sw, 5'd0, 5'd7, 64'h34, 64'h3333_4444, {1'b0, 5'd7, 64'h5555}, 0);
        add_op("fwd_off_rd", op_ld, 5'd8, 5'd0, 64'h30, '0, '0, 0);
        add_op("bp_load", op_ld, 5'd10, 5'd0, 64'h20, '0, '0, 5);
        add_op("bp_lhu", op_lhu, 5'd11, 5'd0, 64'h2a, '0, '0, 3);
        add_op("bp_alu", op_alu, 5'd12, 5'd0, 64'h77, '0, '0, 4);
        add_op("none_op", op_none, 5'd13, 5'd0, 64'h0, '0, '0, 0);
        for (int i = 0; i < 6; i++) begin
            add_op("rnd_sd", op_sd, 5'd0, 5'd2, 64'h40 + (i % 3) * 8,
                   {$random(seed), $random(seed)}, '0, i % 2);
            add_op("rnd_ld", op_ld, 5'd14, 5'd0, 64'h40 + (i % 3) * 8, '0, '0, 0);
        end
    endtask

    initial begin
        int      next_in;
        int      next_out;
        int      cyc;
        int      idle;
        int      stall_left;
        int      lat;
        int      exp_lat;
        int      acc_cyc [MAX_ENT];
        logic    acc;
        logic    leave;
        logic    seen;
        mem_wb_t last_out;

        rst      = 1'b1;
        ex_valid = 1'b0;
        ex_in    = '0;
        wb_fwd   = '0;
        wb_ready = 1'b1;
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            mirror[i] = '0;
        end
        build_table();
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        @(posedge clk);
        assert (!wb_valid && ex_ready)
            else report_failure("wb_valid or ex_ready wrong after reset");

        next_in    = 0;
        next_out   = 0;
        cyc        = 0;
        idle       = 0;
        seen       = 1'b0;
        stall_left = t_stall[0];
        #1;
        ex_valid = 1'b1;
        ex_in    = t_ex[0];
        wb_fwd   = t_fwd[0];
        wb_ready = (stall_left == 0);

        while (next_out < n_ent) begin
            @(posedge clk);
            cyc++;
            idle++;
            acc   = ex_valid && ex_ready;
            leave = wb_valid && wb_ready;
            if (next_out < next_in && touches_ram(t_ex[next_out].op) && !wb_valid) begin
                assert (!ex_ready)
                    else report_failure("ex_ready high while a memory access is pending");
            end
            if (wb_valid) begin
                if (!seen) begin
                    seen    = 1'b1;
                    lat     = cyc - acc_cyc[next_out];
                    exp_lat = touches_ram(t_ex[next_out].op) ? `MEM_WAIT + 1 : 1;
                    assert (lat == exp_lat)
                        else report_failure($sformatf("error: %s latency expected %0d actual %0d",
                                                      t_name[next_out], exp_lat, lat));
                end else begin
                    assert (wb_out === last_out)
                        else report_failure($sformatf(
                            "error: %s stalled wb_out expected %h actual %h",
                            t_name[next_out], last_out, wb_out));
                end
                last_out = wb_out;
                if (stall_left > 0) begin
                    stall_left--;
                end
            end
            if (leave) begin
                assert (next_out < next_in)
                    else report_failure("record delivered that was never accepted");
                assert (wb_out.pc === t_ex[next_out].pc)
                    else report_failure($sformatf("error: %s pc expected %h actual %h",
                                                  t_name[next_out], t_ex[next_out].pc,
                                                  wb_out.pc));
                assert (wb_out.wen === e_wen[next_out] && wb_out.rd === e_rd[next_out])
                    else report_failure($sformatf("error: %s wen/rd expected %b/%0d actual %b/%0d",
                                                  t_name[next_out], e_wen[next_out],
                                                  e_rd[next_out], wb_out.wen, wb_out.rd));
                if (e_wen[next_out]) begin
                    assert (wb_out.wdata === e_wdata[next_out])
                        else report_failure($sformatf("error: %s wdata expected %h actual %h",
                                                      t_name[next_out], e_wdata[next_out],
                                                      wb_out.wdata));
                end
                next_out++;
                seen = 1'b0;
                idle = 0;
                if (next_out < n_ent) begin
                    stall_left = t_stall[next_out];
                end
            end
            if (acc) begin
                acc_cyc[next_in] = cyc;
                next_in++;
            end
            if (idle > TIMEOUT) begin
                report_failure("timeout waiting for wb_valid");
            end
            #1;
            ex_valid = (next_in < n_ent);
            if (next_in < n_ent) begin
                ex_in = t_ex[next_in];
            end
            if (next_out < n_ent) begin
                wb_fwd = t_fwd[next_out];
            end
            wb_ready = (stall_left == 0);
        end

        // nothing extra may come out once the stream is drained
        repeat (5) begin
            @(posedge clk);
            assert (!wb_valid)
                else report_failure("wb_valid high after the last record left");
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: mem_sva.sv
// ----------------------------------------------------------------------
// memory stage assertions
// bound into the stage register to check back-pressure and stalls
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module mem_sva (
    input logic             clk,
    input logic             rst,
    input mem_pkg::mem_wb_t wb_out,
    input logic             wb_valid,
    input logic             wb_ready,
    input logic             ex_ready,
    input logic             req_valid,
    input logic             done
);

    // a stalled record stays put until writeback takes it
    property wb_hold_p;
        @(posedge clk) disable iff (rst)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb_out);
    endproperty

    // pending access blocks execute
    property mem_stall_p;
        @(posedge clk) disable iff (rst)
        req_valid && !done |-> !ex_ready;
    endproperty

    wb_hold_a: assert property (wb_hold_p)
        else $error("writeback record changed while stalled");
    mem_stall_a: assert property (mem_stall_p)
        else $error("execute accepted while a memory access was pending");

endmodule

bind mem_stage mem_sva i_sva (
    .clk       (clk),
    .rst       (rst),
    .wb_out    (wb_out),
    .wb_valid  (wb_valid),
    .wb_ready  (wb_ready),
    .ex_ready  (ex_ready),
    .req_valid (req_valid),
    .done      (done)
);

// File: mem_top.sv
// ----------------------------------------------------------------------
// memory access stage top
// stage register, load/store aligner and data memory controller
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module mem_top (
    input  logic             clk,
    input  logic             rst,
    input  mem_pkg::ex_mem_t ex_in,
    input  logic             ex_valid,
    output logic             ex_ready,
    input  mem_pkg::wb_fwd_t wb_fwd,
    output mem_pkg::mem_wb_t wb_out,
    output logic             wb_valid,
    input  logic             wb_ready
);
    import mem_pkg::*;

    mem_op_t   held_op;
    xaddr_t    held_addr;
    xdata_t    store_src;
    xdata_t    load_value;
    xdata_t    rdata;
    dmem_req_t req;
    logic      req_valid;
    logic      done;
    logic      ack;

    mem_stage i_stage (
        .clk        (clk),
        .rst        (rst),
        .ex_in      (ex_in),
        .ex_valid   (ex_valid),
        .ex_ready   (ex_ready),
        .wb_fwd     (wb_fwd),
        .load_value (load_value),
        .held_op    (held_op),
        .held_addr  (held_addr),
        .store_src  (store_src),
        .req_valid  (req_valid),
        .done       (done),
        .ack        (ack),
        .wb_out     (wb_out),
        .wb_valid   (wb_valid),
        .wb_ready   (wb_ready)
    );

    lsu_align i_align (
        .op         (held_op),
        .addr       (held_addr),
        .store_src  (store_src),
        .rdata      (rdata),
        .req        (req),
        .load_value (load_value)
    );

    dmem_ctrl i_dmem (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .done       (done),
        .rdata      (rdata),
        .ack        (ack)
    );

endmodule

// File: mem_stage.sv
// ----------------------------------------------------------------------
// memory stage register
// holds one execute record, forwards the store operand from writeback,
// stalls memory operations until the RAM is done and builds the
// writeback record
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module mem_stage (
    input  logic               clk,
    input  logic               rst,
    input  mem_pkg::ex_mem_t   ex_in,
    input  logic               ex_valid,
    output logic               ex_ready,
    input  mem_pkg::wb_fwd_t   wb_fwd,
    input  mem_pkg::xdata_t    load_value,
    output mem_pkg::mem_op_t   held_op,
    output mem_pkg::xaddr_t    held_addr,
    output mem_pkg::xdata_t    store_src,
    output logic               req_valid,
    input  logic               done,
    output logic               ack,
    output mem_pkg::mem_wb_t   wb_out,
    output logic               wb_valid,
    input  logic               wb_ready
);
    import mem_pkg::*;

    ex_mem_t held;          // record being worked on
    logic    held_valid;
    logic    is_load;
    logic    is_mem;
    logic    fwd_hit;
    logic    take;

    assign is_load = held.op inside {op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu};
    assign is_mem  = is_load || (held.op inside {op_sb, op_sh, op_sw, op_sd});

    // handshakes on both sides
    assign wb_valid = held_valid && (!is_mem || done);
    assign ack      = wb_valid && wb_ready;
    assign ex_ready = !held_valid || ack;
    assign take     = ex_valid && ex_ready;

    // request to the controller stays up until the item leaves
    assign req_valid = held_valid && is_mem;
    assign held_op   = held.op;
    assign held_addr = held.alu_out;

    // writeback result for the register that the store reads
    assign fwd_hit   = wb_fwd.wen && (wb_fwd.rd != '0) && (wb_fwd.rd == held.rs2);
    assign store_src = fwd_hit ? wb_fwd.wdata : held.src2;

    always_ff @(posedge clk) begin
        if (rst) begin
            held_valid <= 1'b0;
        end else if (ex_ready) begin
            held_valid <= ex_valid;     // refill or drain
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            held <= ex_in;
        end else if (held_valid && fwd_hit) begin
            held.src2 <= wb_fwd.wdata;  // keep forwarded value while stalled
        end
    end

    // writeback record
    always_comb begin
        wb_out.pc    = held.pc;
        wb_out.rd    = held.rd;
        wb_out.wen   = is_load || (held.op == op_alu);
        wb_out.wdata = is_load ? load_value : held.alu_out;
    end

endmodule

// File: dmem_ctrl.sv
// ----------------------------------------------------------------------
// data memory controller
// idle/wait/done FSM with a wait-state counter in front of a
// byte-strobed on-chip data RAM
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "mem_settings.svh"

module dmem_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    input  mem_pkg::dmem_req_t req,
    output logic               done,
    output mem_pkg::xdata_t    rdata,
    input  logic               ack
);
    import mem_pkg::*;

    localparam int IDX_W = $clog2(`DMEM_WORDS);
    localparam int CNT_W = $clog2(`MEM_WAIT + 1);

    dmem_state_t      state;
    logic [CNT_W-1:0] wait_cnt;     // cycles spent on the request so far
    logic [IDX_W-1:0] word_idx;
    logic             enter_done;
    logic             ram_we;

    xdata_t ram [`DMEM_WORDS];

    assign word_idx = req.addr[IDX_W+2:3];
    assign done     = (state == dm_done);
    assign ram_we   = enter_done && req.wr;

    // the cycle that sees req_valid in idle counts as the first wait cycle
    always_comb begin
        case (state)
            dm_idle: enter_done = req_valid && (`MEM_WAIT <= 1);
            dm_wait: enter_done = (wait_cnt == CNT_W'(`MEM_WAIT - 1));
            default: enter_done = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= dm_idle;
            wait_cnt <= '0;
        end else begin
            case (state)
                dm_idle: begin
                    if (req_valid) begin
                        wait_cnt <= CNT_W'(1);
                        state    <= enter_done ? dm_done : dm_wait;
                    end
                end
                dm_wait: begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (enter_done) begin
                        state <= dm_done;
                    end
                end
                dm_done: begin
                    if (ack) begin      // item left the stage
                        state <= dm_idle;
                    end
                end
                default: begin
                    state <= dm_idle;
                end
            endcase
        end
    end

    // one write or one read per access, on entry to done
    always_ff @(posedge clk) begin
        for (int b = 0; b < 8; b++) begin
            if (ram_we && req.strb[b]) begin
                ram[word_idx][b*8 +: 8] <= req.wdata[b*8 +: 8];
            end
        end
        if (enter_done && !req.wr) begin
            rdata <= ram[word_idx];     // held through done until ack
        end
    end

endmodule

// File: lsu_align.sv
// ----------------------------------------------------------------------
// load/store aligner
// places store data on its byte lanes with strobes, and pulls the
// addressed bytes out of a read word with sign or zero extension
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module lsu_align (
    input  mem_pkg::mem_op_t   op,
    input  mem_pkg::xaddr_t    addr,
    input  mem_pkg::xdata_t    store_src,
    input  mem_pkg::xdata_t    rdata,
    output mem_pkg::dmem_req_t req,
    output mem_pkg::xdata_t    load_value
);
    import mem_pkg::*;

    logic [2:0] lane;           // byte offset inside the word
    logic [5:0] shamt;          // same offset in bits
    logic       is_store;
    strb_t      size_mask;      // access size as low strobes
    xdata_t     store_bytes;
    xdata_t     lane_data;

    assign lane     = addr[2:0];
    assign shamt    = {lane, 3'b000};
    assign is_store = op inside {op_sb, op_sh, op_sw, op_sd};

    always_comb begin
        case (op)
            op_sb, op_lb, op_lbu: size_mask = 8'h01;
            op_sh, op_lh, op_lhu: size_mask = 8'h03;
            op_sw, op_lw, op_lwu: size_mask = 8'h0f;
            op_sd, op_ld:         size_mask = 8'hff;
            default:              size_mask = 8'h00;
        endcase
    end

    // keep only the bytes that belong to the access
    always_comb begin
        for (int b = 0; b < 8; b++) begin
            store_bytes[b*8 +: 8] = size_mask[b] ? store_src[b*8 +: 8] : 8'h00;
        end
    end

    // store request, address is naturally aligned
    always_comb begin
        req.addr  = addr;
        req.wr    = is_store;
        req.wdata = store_bytes << shamt;
        req.strb  = is_store ? strb_t'(size_mask << lane) : '0;
    end

    // addressed bytes moved down to lane 0
    assign lane_data = rdata >> shamt;

    always_comb begin
        case (op)
            op_lb: begin
                load_value = {{56{lane_data[7]}}, lane_data[7:0]};
            end
            op_lh: begin
                load_value = {{48{lane_data[15]}}, lane_data[15:0]};
            end
            op_lw: begin
                load_value = {{32{lane_data[31]}}, lane_data[31:0]};
            end
            op_lbu: begin
                load_value = {56'h0, lane_data[7:0]};
            end
            op_lhu: begin
                load_value = {48'h0, lane_data[15:0]};
            end
            op_lwu: begin
                load_value = {32'h0, lane_data[31:0]};
            end
            op_ld: begin
                load_value = rdata;     // full word, lane is always 0
            end
            default: begin
                load_value = '0;
            end
        endcase
    end

endmodule

// File: mem_pkg.sv
// ----------------------------------------------------------------------
// memory stage package
// vector types, operation and controller enums, stage records
// ----------------------------------------------------------------------
`include "mem_settings.svh"

package mem_pkg;

    typedef logic [`XLEN-1:0]   xdata_t;
    typedef logic [`XLEN-1:0]   xaddr_t;
    typedef logic [4:0]         reg_idx_t;
    typedef logic [`XLEN/8-1:0] strb_t;

    // compact memory operation from execute
    typedef enum logic [3:0] {
        op_alu  = 4'd0,     // write back alu_out
        op_lb   = 4'd1,
        op_lh   = 4'd2,
        op_lw   = 4'd3,
        op_ld   = 4'd4,
        op_lbu  = 4'd5,
        op_lhu  = 4'd6,
        op_lwu  = 4'd7,
        op_sb   = 4'd8,
        op_sh   = 4'd9,
        op_sw   = 4'd10,
        op_sd   = 4'd11,
        op_none = 4'd15     // no register write
    } mem_op_t;

    typedef enum logic [1:0] {
        dm_idle,
        dm_wait,
        dm_done
    } dmem_state_t;

    typedef struct packed {
        xaddr_t   pc;
        reg_idx_t rd;
        reg_idx_t rs2;
        mem_op_t  op;
        xdata_t   alu_out;    // effective address or alu result
        xdata_t   src2;       // store operand
    } ex_mem_t;

    typedef struct packed {
        xaddr_t   pc;
        reg_idx_t rd;
        logic     wen;
        xdata_t   wdata;
    } mem_wb_t;

    typedef struct packed {
        logic     wen;
        reg_idx_t rd;
        xdata_t   wdata;
    } wb_fwd_t;

    typedef struct packed {
        xaddr_t   addr;
        logic     wr;
        xdata_t   wdata;
        strb_t    strb;
    } dmem_req_t;

endpackage

// File: mem_settings.svh
// ----------------------------------------------------------------------
// memory stage settings
// data and address width, data RAM depth and the fixed RAM wait count
// ----------------------------------------------------------------------
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// width of data words and byte addresses
`define XLEN 64

// data RAM depth in 64-bit words
`define DMEM_WORDS 256

// cycles from request to completed access
`define MEM_WAIT 2

`endif
